// ==== verilog.f ====
verilog/spw_char_pkg.sv
verilog/spw_link_pkg.sv
verilog/spw_tx_credit.sv
verilog/spw_tx_sequencer.sv
verilog/spw_tx_ds_serializer.sv
verilog/spw_tx_top.sv
verif/spw_tx_assertions.sv
verif/spw_tx_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# Build and run the SpaceWire transmitter testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f verilog.f --top-module spw_tx_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vspw_tx_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Regression failed" "$LOG"; then
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi
exit 0

// ==== verif/spw_tx_trace.txt ====
# P null fct | W word | G got FCT | R FCT request | I cycles | Q ready level
# E kind(F D P X) payload count, expected non-NULL characters in line order
I 6
P 1 0
I 60
P 1 1
E F 00 7
E D 41 1
E D a5 1
E P 00 1
E X 00 2
E D ff 1
E D 00 1
E D 7e 1
E F 00 1
E D c3 1
E P 00 1
W 041
I 20
Q 0
G
W 0a5
W 100
W 102
W 103
W 0ff
W 000
W 07e
W 0c3
I 60
Q 0
R
G
W 17c

// ==== verif/spw_tx_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module spw_tx_tb;

	localparam int WAIT_LIMIT = 3000;

	logic       pclk_tx;
	logic       enable_tx;
	logic       send_null_tx;
	logic       send_fct_tx;
	logic [8:0] data_tx_i;
	logic       txwrite_tx;
	logic       gotfct_tx;
	logic       send_fct_now;
	logic       tx_dout_e;
	logic       tx_sout_e;
	logic       ready_tx_data;

	// Expected characters, kind letter and payload
	int         exp_kind[$];
	int         exp_payload[$];

	// DS decoder state
	logic       last_xor;
	logic [9:0] rx_bits;
	int         bit_idx;
	logic [7:0] rx_prev_payload;
	logic       esc_pending;
	logic       lines_enabled;
	int         nchar_count;
	int         grant_count;

	spw_tx_top spw_tx_top_i (
		.pclk_tx       (pclk_tx),
		.enable_tx     (enable_tx),
		.send_null_tx  (send_null_tx),
		.send_fct_tx   (send_fct_tx),
		.data_tx_i     (data_tx_i),
		.txwrite_tx    (txwrite_tx),
		.gotfct_tx     (gotfct_tx),
		.send_fct_now  (send_fct_now),
		.tx_dout_e     (tx_dout_e),
		.tx_sout_e     (tx_sout_e),
		.ready_tx_data (ready_tx_data)
	);

	// Serializer lines and credit counters seen from the top level
	bind spw_tx_top spw_tx_assertions checks_i (
		.pclk_tx      (pclk_tx),
		.enable_tx    (enable_tx),
		.line_d       (tx_dout_e),
		.line_s       (tx_sout_e),
		.credit_cnt   (spw_tx_credit_i.credit_cnt),
		.fct_owed_cnt (spw_tx_credit_i.fct_owed_cnt)
	);

	initial
	begin
		pclk_tx = 1'b0;
	end

	always #50 pclk_tx = ~pclk_tx;

	// --------------------------------------------------------------------------
	// Reporting
	// --------------------------------------------------------------------------
	task automatic abort_run(input string msg);
	begin
		$display("%s", msg);
		$display("Regression failed");
		$fatal(1, "run stopped");
	end
	endtask

	task automatic compare(input string name, input int expected, input int actual);
	begin
		if (expected != actual)
			abort_run($sformatf("ERROR %0t %s expected %0h got %0h", $time, name,
				expected, actual));
	end
	endtask

	// --------------------------------------------------------------------------
	// DS decoder, one bit wherever data XOR strobe moves
	// --------------------------------------------------------------------------
	task automatic finish_char();
		int   kind_c;
		int   payload;
		logic [1:0] code;
	begin
		compare("parity", 1, int'(^{rx_prev_payload, rx_bits[1:0]}));
		if (rx_bits[1])
		begin
			code            = {rx_bits[2], rx_bits[3]};
			rx_prev_payload = {6'd0, code};
			payload         = 0;
			if (code == 2'b11)
			begin
				if (esc_pending)
					abort_run("Two escape codes in a row on the DS lines");
				esc_pending = 1'b1;
				return;
			end
			if (esc_pending)
			begin
				if (code != 2'b00)
					abort_run("Escape code followed by something other than FCT");
				esc_pending = 1'b0;
				return;
			end
			kind_c = (code == 2'b00) ? int'("F") : (code == 2'b01) ? int'("P") : int'("X");
		end
		else
		begin
			if (esc_pending)
				abort_run("Escape code followed by a data character");
			rx_prev_payload = rx_bits[9:2];
			payload         = int'(rx_bits[9:2]);
			kind_c          = int'("D");
		end
		if (kind_c == int'("F") && !send_fct_tx)
			abort_run("FCT seen on the line before send_fct_tx was raised");
		if (kind_c != int'("F"))
		begin
			nchar_count++;
			if (nchar_count > 8 * grant_count)
				abort_run("More N-chars sent than the credit granted by received FCTs");
		end
		if (exp_kind.size() == 0)
			abort_run("Character decoded with no expected character left");
		compare("char_kind", exp_kind.pop_front(), kind_c);
		compare("char_payload", exp_payload.pop_front(), payload);
	end
	endtask

	always @(negedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			last_xor        = 1'b0;
			bit_idx         = 0;
			rx_bits         = 10'd0;
			rx_prev_payload = 8'd0;
			esc_pending     = 1'b0;
		end
		else if ((tx_dout_e ^ tx_sout_e) != last_xor)
		begin
			last_xor = tx_dout_e ^ tx_sout_e;
			if (!lines_enabled)
				abort_run("DS lines moved before send_null_tx was raised");
			rx_bits[bit_idx] = tx_dout_e;
			bit_idx++;
			if (bit_idx >= 2 && bit_idx == (rx_bits[1] ? 4 : 10))
			begin
				finish_char();
				bit_idx = 0;
				rx_bits = 10'd0;
			end
		end
	end

	// --------------------------------------------------------------------------
	// Stimulus tasks, all driven on the falling edge
	// --------------------------------------------------------------------------
	task automatic write_word(input logic [8:0] word);
		int gap;
		int waited;
	begin
		gap = int'($urandom % 4);
		repeat (gap) @(negedge pclk_tx);
		@(negedge pclk_tx);
		data_tx_i  = word;
		txwrite_tx = 1'b1;
		waited     = 0;
		while (!ready_tx_data)
		begin
			if (waited > WAIT_LIMIT)
				abort_run($sformatf("Host word %h was never accepted", word));
			@(negedge pclk_tx);
			waited++;
		end
		@(negedge pclk_tx);
		txwrite_tx = 1'b0;
	end
	endtask

	task automatic pulse_gotfct();
	begin
		@(negedge pclk_tx);
		gotfct_tx   = 1'b1;
		grant_count++;
		@(negedge pclk_tx);
		gotfct_tx   = 1'b0;
	end
	endtask

	task automatic pulse_fct_request();
	begin
		@(negedge pclk_tx);
		send_fct_now = 1'b1;
		@(negedge pclk_tx);
		send_fct_now = 1'b0;
	end
	endtask

	task automatic run_trace();
		int    fd;
		int    a;
		int    b;
		int    k;
		string line;
	begin
		fd = $fopen("verif/spw_tx_trace.txt", "r");
		if (fd == 0)
			abort_run("Could not open the trace file verif/spw_tx_trace.txt");
		while (!$feof(fd))
		begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 1 || line[0] == "#" || line[0] == "\n")
				continue;
			case (line[0])
				"P":
				begin
					if ($sscanf(line, "P %d %d", a, b) != 2)
						abort_run({"Malformed trace line: ", line});
					@(negedge pclk_tx);
					send_null_tx = a[0];
					send_fct_tx  = b[0];
					if (a[0])
						lines_enabled = 1'b1;
				end
				"I":
				begin
					if ($sscanf(line, "I %d", a) != 1)
						abort_run({"Malformed trace line: ", line});
					repeat (a) @(negedge pclk_tx);
				end
				"W":
				begin
					if ($sscanf(line, "W %h", a) != 1)
						abort_run({"Malformed trace line: ", line});
					write_word(a[8:0]);
				end
				"Q":
				begin
					if ($sscanf(line, "Q %d", a) != 1)
						abort_run({"Malformed trace line: ", line});
					@(negedge pclk_tx);
					compare("ready_tx_data", a, int'(ready_tx_data));
				end
				"G": pulse_gotfct();
				"R": pulse_fct_request();
				"E":
				begin
					if ($sscanf(line, "E %c %h %d", k, a, b) != 3)
						abort_run({"Malformed trace line: ", line});
					repeat (b)
					begin
						exp_kind.push_back(k);
						exp_payload.push_back(a);
					end
				end
				default: abort_run({"Unknown trace command: ", line});
			endcase
		end
		$fclose(fd);
	end
	endtask

	// --------------------------------------------------------------------------
	// Main sequence
	// --------------------------------------------------------------------------
	initial
	begin
		int waited;
		void'($urandom(32'h2863eb05));
		enable_tx     = 1'b0;
		send_null_tx  = 1'b0;
		send_fct_tx   = 1'b0;
		data_tx_i     = 9'd0;
		txwrite_tx    = 1'b0;
		gotfct_tx     = 1'b0;
		send_fct_now  = 1'b0;
		lines_enabled = 1'b0;
		nchar_count   = 0;
		grant_count   = 0;

		repeat (4) @(negedge pclk_tx);
		compare("tx_dout_e", 0, int'(tx_dout_e));
		compare("tx_sout_e", 0, int'(tx_sout_e));
		compare("ready_tx_data", 0, int'(ready_tx_data));
		enable_tx = 1'b1;
		@(negedge pclk_tx);
		compare("ready_tx_data", 1, int'(ready_tx_data));

		run_trace();

		// Drain the expected characters
		waited = 0;
		while (exp_kind.size() != 0)
		begin
			if (waited > WAIT_LIMIT)
				abort_run($sformatf("%0d expected characters never appeared",
					exp_kind.size()));
			@(negedge pclk_tx);
			waited++;
		end
		repeat (20) @(negedge pclk_tx);

		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/spw_tx_assertions.sv ====
`timescale 1ns/1ns
`default_nettype none

module spw_tx_assertions (
	input  logic       pclk_tx,
	input  logic       enable_tx,
	input  logic       line_d,
	input  logic       line_s,
	input  logic [5:0] credit_cnt,
	input  logic [2:0] fct_owed_cnt
);

	// --------------------------------------------------------------------------
	// DS encoding, one line moves per bit
	// --------------------------------------------------------------------------
	ds_one_line: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		!($changed(line_d) && $changed(line_s)))
		else $error("data and strobe lines changed in the same cycle");

	// --------------------------------------------------------------------------
	// Counter ceilings
	// --------------------------------------------------------------------------
	credit_ceiling: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		credit_cnt <= 6'(spw_link_pkg::CREDIT_MAX))
		else $error("credit counter above its ceiling");

	owed_ceiling: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		fct_owed_cnt <= 3'(spw_link_pkg::FCT_OWED_MAX))
		else $error("owed FCT counter above its ceiling");

endmodule

`default_nettype wire

// ==== verilog/spw_tx_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module spw_tx_top (
	input  logic       pclk_tx,
	input  logic       enable_tx,
	input  logic       send_null_tx,
	input  logic       send_fct_tx,
	input  logic [8:0] data_tx_i,
	input  logic       txwrite_tx,
	input  logic       gotfct_tx,
	input  logic       send_fct_now,
	output logic       tx_dout_e,
	output logic       tx_sout_e,
	output logic       ready_tx_data
);

	spw_char_pkg::char_req_t    char_req;
	spw_char_pkg::char_kind_t   char_done_kind;
	spw_link_pkg::credit_stat_t credit_stat;
	logic                       char_done;

	spw_tx_sequencer spw_tx_sequencer_i (
		.pclk_tx        (pclk_tx),
		.enable_tx      (enable_tx),
		.send_null_tx   (send_null_tx),
		.send_fct_tx    (send_fct_tx),
		.data_tx_i      (data_tx_i),
		.txwrite_tx     (txwrite_tx),
		.credit_stat    (credit_stat),
		.char_done      (char_done),
		.char_done_kind (char_done_kind),
		.ready_tx_data  (ready_tx_data),
		.char_req       (char_req)
	);

	// Counters see each completed character
	spw_tx_credit spw_tx_credit_i (
		.pclk_tx        (pclk_tx),
		.enable_tx      (enable_tx),
		.gotfct_tx      (gotfct_tx),
		.send_fct_now   (send_fct_now),
		.char_done      (char_done),
		.char_done_kind (char_done_kind),
		.credit_stat    (credit_stat)
	);

	spw_tx_ds_serializer spw_tx_ds_serializer_i (
		.pclk_tx        (pclk_tx),
		.enable_tx      (enable_tx),
		.char_req       (char_req),
		.char_done      (char_done),
		.char_done_kind (char_done_kind),
		.tx_dout_e      (tx_dout_e),
		.tx_sout_e      (tx_sout_e)
	);

endmodule

`default_nettype wire

// ==== verilog/spw_tx_ds_serializer.sv ====
`timescale 1ns/1ns
`default_nettype none

module spw_tx_ds_serializer (
	input  logic                     pclk_tx,
	input  logic                     enable_tx,
	input  spw_char_pkg::char_req_t  char_req,
	output logic                     char_done,
	output spw_char_pkg::char_kind_t char_done_kind,
	output logic                     tx_dout_e,
	output logic                     tx_sout_e
);

	logic                     busy;
	logic [3:0]               bit_cnt;
	logic [9:0]               shift_q;
	logic [7:0]               prev_payload;
	spw_char_pkg::char_kind_t cur_kind;
	logic                     load;
	logic                     parity;
	logic [1:0]               ctrl_code;
	logic [9:0]               char_bits;
	logic [3:0]               char_len;
	logic [7:0]               next_payload;

	// Last bit of the character is on its way to the line
	assign char_done      = busy && (bit_cnt == 4'd1);
	assign char_done_kind = cur_kind;
	assign load           = char_req.valid && (!busy || char_done);

	// --------------------------------------------------------------------------
	// Character assembly, bit 0 leaves first
	// --------------------------------------------------------------------------
	always_comb
	begin
		case (char_req.kind)
			spw_char_pkg::EOP:  ctrl_code = spw_char_pkg::EOP_CODE;
			spw_char_pkg::EEP:  ctrl_code = spw_char_pkg::EEP_CODE;
			spw_char_pkg::NULL: ctrl_code = spw_char_pkg::ESC_CODE;
			default:            ctrl_code = spw_char_pkg::FCT_CODE;
		endcase
	end

	always_comb
	begin
		if (char_req.kind == spw_char_pkg::DATA)
		begin
			// Flag is 0 here
			parity       = ~(^prev_payload);
			char_bits    = {char_req.payload, 1'b0, parity};
			char_len     = 4'(spw_char_pkg::DATA_CHAR_BITS);
			next_payload = char_req.payload;
		end
		else if (char_req.kind == spw_char_pkg::NULL)
		begin
			// ESC then FCT; the ESC code has even ones, so the FCT parity is 0
			parity       = ^prev_payload;
			char_bits    = {2'b00, spw_char_pkg::FCT_CODE[0], spw_char_pkg::FCT_CODE[1],
				1'b1, 1'b0, ctrl_code[0], ctrl_code[1], 1'b1, parity};
			char_len     = 4'(spw_char_pkg::NULL_BITS);
			next_payload = {6'd0, spw_char_pkg::FCT_CODE};
		end
		else
		begin
			parity       = ^prev_payload;
			char_bits    = {6'd0, ctrl_code[0], ctrl_code[1], 1'b1, parity};
			char_len     = 4'(spw_char_pkg::CTRL_CHAR_BITS);
			next_payload = {6'd0, ctrl_code};
		end
	end

	always_ff @(posedge pclk_tx)
	begin
		if (load)
			shift_q <= char_bits;
		else if (busy)
			shift_q <= {1'b0, shift_q[9:1]};
	end

	// --------------------------------------------------------------------------
	// Bit counter and DS lines
	// --------------------------------------------------------------------------
	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			busy         <= 1'b0;
			bit_cnt      <= 4'd0;
			cur_kind     <= spw_char_pkg::NULL;
			prev_payload <= 8'd0;
			tx_dout_e    <= 1'b0;
			tx_sout_e    <= 1'b0;
		end
		else
		begin
			if (busy)
			begin
				tx_dout_e <= shift_q[0];
				// Strobe carries the edge when data repeats
				if (shift_q[0] == tx_dout_e)
					tx_sout_e <= ~tx_sout_e;
				bit_cnt <= bit_cnt - 4'd1;
			end
			if (load)
			begin
				busy         <= 1'b1;
				bit_cnt      <= char_len;
				cur_kind     <= char_req.kind;
				prev_payload <= next_payload;
			end
			else if (char_done)
				busy <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/spw_tx_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module spw_tx_sequencer (
	input  logic                       pclk_tx,
	input  logic                       enable_tx,
	input  logic                       send_null_tx,
	input  logic                       send_fct_tx,
	input  logic [8:0]                 data_tx_i,
	input  logic                       txwrite_tx,
	input  spw_link_pkg::credit_stat_t credit_stat,
	input  logic                       char_done,
	input  spw_char_pkg::char_kind_t   char_done_kind,
	output logic                       ready_tx_data,
	output spw_char_pkg::char_req_t    char_req
);

	spw_link_pkg::link_state_t state;
	spw_link_pkg::link_state_t state_nxt;
	spw_char_pkg::host_word_u  hold_word;
	spw_char_pkg::char_kind_t  hold_kind;
	spw_char_pkg::char_kind_t  run_kind;
	logic                      hold_pending;
	logic                      hold_sending;
	logic                      hold_done;
	logic                      take_word;
	logic                      ready_nxt;

	// --------------------------------------------------------------------------
	// Holding register
	// --------------------------------------------------------------------------
	always_ff @(posedge pclk_tx)
	begin
		if (ready_tx_data && txwrite_tx)
			hold_word <= data_tx_i;
	end

	always_comb
	begin
		if (!hold_word.data.flag)
			hold_kind = spw_char_pkg::DATA;
		else if (hold_word.ctrl.end_code == 2'b00)
			hold_kind = spw_char_pkg::EOP;
		else
			hold_kind = spw_char_pkg::EEP;
	end

	assign take_word = char_req.valid && hold_pending && (char_req.kind == hold_kind);
	assign hold_done = hold_sending && char_done && (char_done_kind == hold_kind);

	always_comb
	begin
		if (ready_tx_data)
			ready_nxt = !txwrite_tx;
		else
			ready_nxt = !hold_pending && (!hold_sending || hold_done);
	end

	// --------------------------------------------------------------------------
	// Character choice
	// --------------------------------------------------------------------------
	// FCT first, then the held word under credit, then NULL
	always_comb
	begin
		if (credit_stat.fct_owed_nz)
			run_kind = spw_char_pkg::FCT;
		else if (hold_pending && credit_stat.has_credit)
			run_kind = hold_kind;
		else
			run_kind = spw_char_pkg::NULL;
	end

	always_comb
	begin
		state_nxt      = state;
		char_req.valid = 1'b0;
		char_req.kind  = spw_char_pkg::NULL;
		case (state)
			spw_link_pkg::START:
			begin
				// Serializer is idle until the first NULL
				if (send_null_tx)
				begin
					char_req.valid = 1'b1;
					state_nxt      = spw_link_pkg::NULLS;
				end
			end
			spw_link_pkg::NULLS:
			begin
				if (char_done)
				begin
					char_req.valid = 1'b1;
					if (send_fct_tx)
					begin
						state_nxt = spw_link_pkg::FCTS;
						if (credit_stat.fct_owed_nz)
							char_req.kind = spw_char_pkg::FCT;
					end
				end
			end
			spw_link_pkg::FCTS:
			begin
				if (char_done)
				begin
					char_req.valid = 1'b1;
					if (credit_stat.fct_owed_nz)
						char_req.kind = spw_char_pkg::FCT;
					else
					begin
						state_nxt     = spw_link_pkg::RUN;
						char_req.kind = run_kind;
					end
				end
			end
			default:
			begin
				if (char_done)
				begin
					char_req.valid = 1'b1;
					char_req.kind  = run_kind;
				end
			end
		endcase
		char_req.payload = (char_req.kind == spw_char_pkg::DATA) ? hold_word.data.value : 8'd0;
	end

	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			state         <= spw_link_pkg::START;
			ready_tx_data <= 1'b0;
			hold_pending  <= 1'b0;
			hold_sending  <= 1'b0;
		end
		else
		begin
			state         <= state_nxt;
			ready_tx_data <= ready_nxt;
			if (ready_tx_data && txwrite_tx)
				hold_pending <= 1'b1;
			else if (take_word)
				hold_pending <= 1'b0;
			if (take_word)
				hold_sending <= 1'b1;
			else if (hold_done)
				hold_sending <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/spw_tx_credit.sv ====
`timescale 1ns/1ns
`default_nettype none

module spw_tx_credit (
	input  logic                       pclk_tx,
	input  logic                       enable_tx,
	input  logic                       gotfct_tx,
	input  logic                       send_fct_now,
	input  logic                       char_done,
	input  spw_char_pkg::char_kind_t   char_done_kind,
	output spw_link_pkg::credit_stat_t credit_stat
);

	logic [5:0] credit_cnt;
	logic [2:0] fct_owed_cnt;
	logic [6:0] credit_nxt;
	logic [3:0] owed_nxt;
	logic       nchar_done;
	logic       fct_done;

	// The FCT inside a NULL has kind NULL, so it never counts here
	assign nchar_done = char_done && (char_done_kind == spw_char_pkg::DATA ||
		char_done_kind == spw_char_pkg::EOP || char_done_kind == spw_char_pkg::EEP);
	assign fct_done   = char_done && (char_done_kind == spw_char_pkg::FCT);

	always_comb
	begin
		credit_nxt = {1'b0, credit_cnt};
		if (gotfct_tx)
			credit_nxt = credit_nxt + 7'(spw_link_pkg::CREDIT_STEP);
		if (credit_nxt > 7'(spw_link_pkg::CREDIT_MAX))
			credit_nxt = 7'(spw_link_pkg::CREDIT_MAX);
		if (nchar_done && credit_nxt != 7'd0)
			credit_nxt = credit_nxt - 7'd1;
	end

	always_comb
	begin
		owed_nxt = {1'b0, fct_owed_cnt};
		if (send_fct_now)
			owed_nxt = owed_nxt + 4'd1;
		if (owed_nxt > 4'(spw_link_pkg::FCT_OWED_MAX))
			owed_nxt = 4'(spw_link_pkg::FCT_OWED_MAX);
		if (fct_done && owed_nxt != 4'd0)
			owed_nxt = owed_nxt - 4'd1;
	end

	// Flags follow the updated counts, so a character finishing now is
	// already accounted for when the next one is chosen
	assign credit_stat.has_credit  = (credit_nxt != 7'd0);
	assign credit_stat.fct_owed_nz = (owed_nxt != 4'd0);

	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			credit_cnt   <= 6'd0;
			fct_owed_cnt <= 3'(spw_link_pkg::FCT_OWED_RESET);
		end
		else
		begin
			credit_cnt   <= credit_nxt[5:0];
			fct_owed_cnt <= owed_nxt[2:0];
		end
	end

endmodule

`default_nettype wire

// ==== verilog/spw_link_pkg.sv ====
`default_nettype none

package spw_link_pkg;

	// --------------------------------------------------------------------------
	// Link start states
	// --------------------------------------------------------------------------
	typedef enum logic [1:0] {
		START,
		NULLS,
		FCTS,
		RUN
	} link_state_t;

	// --------------------------------------------------------------------------
	// Flow control
	// --------------------------------------------------------------------------
	// N-chars granted per received FCT, and the ceiling
	localparam int CREDIT_STEP = 8;
	localparam int CREDIT_MAX  = 56;

	// FCTs owed to the partner, all eight-slot blocks free after reset
	localparam int FCT_OWED_MAX   = 7;
	localparam int FCT_OWED_RESET = 7;

	// Flags that steer the next character
	typedef struct packed {
		logic has_credit;
		logic fct_owed_nz;
	} credit_stat_t;

endpackage

`default_nettype wire

// ==== verilog/spw_char_pkg.sv ====
`default_nettype none

package spw_char_pkg;

	// --------------------------------------------------------------------------
	// Character kinds and bit counts
	// --------------------------------------------------------------------------
	typedef enum logic [2:0] {
		NULL,
		FCT,
		DATA,
		EOP,
		EEP
	} char_kind_t;

	// Bit counts with parity and flag
	localparam int CTRL_CHAR_BITS = 4;
	localparam int DATA_CHAR_BITS = 10;
	localparam int NULL_BITS      = 8;

	// Control codes in line order, left bit goes out first
	localparam logic [1:0] FCT_CODE = 2'b00;
	localparam logic [1:0] EOP_CODE = 2'b01;
	localparam logic [1:0] EEP_CODE = 2'b10;
	localparam logic [1:0] ESC_CODE = 2'b11;

	// --------------------------------------------------------------------------
	// Host word, seen as a data byte or as an end marker
	// --------------------------------------------------------------------------
	typedef struct packed {
		logic       flag;
		logic [7:0] value;
	} host_data_t;

	typedef struct packed {
		logic       flag;
		logic [5:0] unused;
		logic [1:0] end_code;
	} host_ctrl_t;

	typedef union packed {
		host_data_t data;
		host_ctrl_t ctrl;
	} host_word_u;

	typedef struct packed {
		logic       valid;
		char_kind_t kind;
		logic [7:0] payload;
	} char_req_t;

endpackage

`default_nettype wire
